//--- Makefile
VERILATOR ?= verilator
TOP       ?= vcu_tb
FILELIST  ?= vcu_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j 0
PASS_MSG  ?= All tests passed!
SOURCES   := $(wildcard verilog/*.sv) $(wildcard verif/*.sv)

.PHONY: compile run clean

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- vcu_top.f
verilog/vcu_insn_pkg.sv
verilog/vcu_op_pkg.sv
verilog/vcu_vector_alu.sv
verilog/vcu_opcode_ram.sv
verilog/vcu_insn_decoder.sv
verilog/vcu_sequencer.sv
verilog/vcu_microcode_engine.sv
verilog/vcu_writeback.sv
verilog/vcu_top.sv
verif/vcu_tb.sv

//--- verif/vcu_tb.sv
`default_nettype none

module vcu_tb
    import vcu_insn_pkg::*;
    import vcu_op_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int LANES = 8;
    localparam int VEC   = LANES * 16;
    // 22 iterations at under 40 cycles each, opcode loads and idle gaps, with wide margin
    localparam int MAX_CYCLES = 4000;

    typedef struct packed {
        logic [1:0]            port;   // 0 inp, 1 ofmap, 2 acc
        logic [ADDR_WIDTH-1:0] addr;
        logic [VEC-1:0]        data;
    } exp_wr_t;

    logic                  clk = 1'b0;
    logic                  rst;
    vcu_insn_u             insn;
    logic                  work_en;
    opcode_wr_t            w_opcode;
    logic [VEC-1:0]        r_data_acc = '0;
    logic                  r_en_acc;
    logic [ADDR_WIDTH-1:0] r_addr_acc;
    logic [VEC-1:0]        w_data;
    ram_wr_t               w_inp;
    ram_wr_t               w_ofmap;
    ram_wr_t               w_acc;
    logic                  vcu_done;

    logic [VEC-1:0] acc_mem [4096];
    micro_op_t      op_mem [1 << OPCODE_ADDR_WIDTH];
    logic [15:0]    m_add [3];
    logic [15:0]    m_mul [3];
    logic [15:0]    m_cmp;
    logic [31:0]    lcg_state = 32'd72;

    exp_wr_t    exp_mem [64];
    logic [5:0] wr_ptr = '0;
    logic [5:0] rd_ptr = '0;
    exp_wr_t    obs_wr;
    logic       any_en;
    logic       started;
    logic       pending;
    int         cycles = 0;
    int         err_onehot = 0;
    int         err_wr = 0;
    int         err_done = 0;
    int         err_idle = 0;
    int         end_err = 0;
    int         err_mark = 0;
    int         tests_run = 0;
    int         tests_failed = 0;

    always #4 clk = ~clk;

    vcu_top #(
        .LANES (LANES)
    ) i_vcu_top (
        .clk        (clk),
        .rst        (rst),
        .insn       (insn),
        .work_en    (work_en),
        .w_opcode   (w_opcode),
        .r_data_acc (r_data_acc),
        .r_en_acc   (r_en_acc),
        .r_addr_acc (r_addr_acc),
        .w_data     (w_data),
        .w_inp      (w_inp),
        .w_ofmap    (w_ofmap),
        .w_acc      (w_acc),
        .vcu_done   (vcu_done)
    );

    // accumulator ram, data one cycle after the read strobe
    always @(posedge clk)
    begin
        if (r_en_acc)
            r_data_acc <= acc_mem[r_addr_acc];
    end

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (any_en)
            rd_ptr <= rd_ptr + 6'd1;
        if (rst)
        begin
            started <= 1'b0;
            pending <= 1'b0;
        end
        else if (work_en)
        begin
            started <= 1'b1;
            pending <= 1'b1;
        end
        else if (vcu_done)
            pending <= 1'b0;
        if (cycles == MAX_CYCLES)
        begin
            $display("timeout after %0d cycles, the unit never finished", cycles);
            $display("Test failures found");
            $finish;
        end
    end

    assign any_en       = w_inp.en || w_ofmap.en || w_acc.en;
    assign obs_wr.port  = w_ofmap.en ? 2'd1 : (w_acc.en ? 2'd2 : 2'd0);
    assign obs_wr.addr  = w_ofmap.en ? w_ofmap.addr : (w_acc.en ? w_acc.addr : w_inp.addr);
    assign obs_wr.data  = w_data;

    ////////////////////
    // checkers
    ////////////////////
    a_one_hot: assert property (@(posedge clk) disable iff (rst)
        $onehot0({w_inp.en, w_ofmap.en, w_acc.en}))
    else
    begin
        $display("%0t: more than one write strobe at once", $time);
        err_onehot++;
    end

    a_write: assert property (@(posedge clk) disable iff (rst)
        any_en |-> ((rd_ptr != wr_ptr) && (obs_wr == exp_mem[rd_ptr])))
    else
    begin
        if (rd_ptr == wr_ptr)
            $display("%0t: write strobe while no write was expected", $time);
        else
            $display("[ERROR] %0t w_data: port/addr/data expected %0d/%h/%h, got %0d/%h/%h",
                     $time, exp_mem[rd_ptr].port, exp_mem[rd_ptr].addr, exp_mem[rd_ptr].data,
                     obs_wr.port, obs_wr.addr, obs_wr.data);
        err_wr++;
    end

    // one pulse per instruction
    a_done_pulse: assert property (@(posedge clk) disable iff (rst) vcu_done |-> pending)
    else
    begin
        $display("%0t: vcu_done high with no instruction pending", $time);
        err_done++;
    end

    a_quiet: assert property (@(posedge clk) disable iff (rst)
        !started |-> !(r_en_acc || any_en || vcu_done))
    else
    begin
        $display("%0t: ram strobe or vcu_done before the first instruction", $time);
        err_idle++;
    end

    ////////////////////
    // reference model
    ////////////////////
    function automatic logic [15:0] rand16();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[30:15];
    endfunction

    function automatic micro_op_t make_op(input logic [3:0] op, input logic dest,
                                          input logic [1:0] sel);
        micro_op_t u;
        u      = '0;
        u.op   = op;
        u.dest = dest;
        u.sel  = sel;
        return u;
    endfunction

    function automatic logic [15:0] lane_op(input micro_op_t u, input logic [15:0] i,
                                            input logic [15:0] c);
        logic [15:0] a;
        logic [15:0] m;
        a = (u.sel == 2'd3) ? 16'd0 : m_add[u.sel];
        m = (u.sel == 2'd3) ? 16'd0 : m_mul[u.sel];
        case (u.op)
            OP_ADD:  return i + a;
            OP_MUL:  return i * m;
            OP_MAX:  return ($signed(i) > $signed(m_cmp)) ? i : m_cmp;
            OP_ACC:  return i + c;
            default: return i;
        endcase
    endfunction

    function automatic logic [VEC-1:0] model_vector(input logic [VEC-1:0] v,
        input logic [OPCODE_ADDR_WIDTH-1:0] base, input logic [4:0] n_ops);
        logic [VEC-1:0] res;
        logic [15:0]    it;
        logic [15:0]    c;
        micro_op_t      u;
        for (int l = 0; l < LANES; l++)
        begin
            it = v[l*16 +: 16];
            c  = '0;
            for (int j = 0; j < int'(n_ops); j++)
            begin
                u = op_mem[OPCODE_ADDR_WIDTH'(int'(base) + j)];
                if (u.dest)
                    c = lane_op(u, it, c);
                else
                    it = lane_op(u, it, c);
            end
            res[l*16 +: 16] = it;
        end
        return res;
    endfunction

    function automatic int total_errors();
        return err_onehot + err_wr + err_done + err_idle + end_err;
    endfunction

    ////////////////////
    // stimulus
    ////////////////////
    task automatic load_op(input logic [OPCODE_ADDR_WIDTH-1:0] addr, input micro_op_t u);
        @(posedge clk);
        w_opcode <= '{en: 1'b1, addr: addr, data: u};
        op_mem[addr] = u;
    endtask

    task automatic send_insn(input vcu_insn_u u);
        @(posedge clk);
        w_opcode <= '0;
        insn     <= u;
        work_en  <= 1'b1;
        @(posedge clk);
        work_en  <= 1'b0;
    endtask

    task automatic wait_done();
        @(negedge clk);
        while (!vcu_done)
            @(negedge clk);
    endtask

    task automatic run_compute(input logic [ADDR_WIDTH-1:0] in_addr,
        input logic [ADDR_WIDTH-1:0] out_addr, input logic [OPCODE_ADDR_WIDTH-1:0] op_addr,
        input logic [4:0] n_ops, input logic [ADDR_WIDTH-1:0] len,
        input logic [1:0] mode, input logic fpu);
        vcu_insn_u      u;
        logic [VEC-1:0] v;
        u = '0;
        u.comp.data_in_addr   = in_addr;
        u.comp.data_out_addr  = out_addr;
        u.comp.opcode_addr    = op_addr;
        u.comp.opcode_count   = n_ops;
        u.comp.compute_length = len;
        u.comp.out_mode       = mode;
        u.comp.fpu_work       = fpu;
        for (int k = 0; k <= int'(len); k++)
        begin
            v = acc_mem[ADDR_WIDTH'(int'(in_addr) + k)];
            if (fpu)
                v = model_vector(v, op_addr, n_ops);
            if (mode != 2'd3)
            begin
                exp_mem[wr_ptr] = '{port: mode, addr: ADDR_WIDTH'(int'(out_addr) + k), data: v};
                wr_ptr = wr_ptr + 6'd1;
            end
        end
        send_insn(u);
        wait_done();
    endtask

    task automatic run_config(input logic [15:0] a0, input logic [15:0] a1,
        input logic [15:0] a2, input logic [15:0] m0, input logic [15:0] m1,
        input logic [15:0] m2, input logic [15:0] cmp);
        vcu_insn_u u;
        u = '0;
        u.cfg.insn_type     = 1'b1;
        u.cfg.add_const[0]  = a0;
        u.cfg.add_const[1]  = a1;
        u.cfg.add_const[2]  = a2;
        u.cfg.mul_const[0]  = m0;
        u.cfg.mul_const[1]  = m1;
        u.cfg.mul_const[2]  = m2;
        u.cfg.compare_const = cmp;
        m_add = '{a0, a1, a2};
        m_mul = '{m0, m1, m2};
        m_cmp = cmp;
        send_insn(u);
        wait_done();
    endtask

    task automatic end_test(input string name);
        int errs;
        a_all_written: assert (rd_ptr == wr_ptr)
        else
        begin
            $display("%0t: %0d expected writes never arrived", $time, wr_ptr - rd_ptr);
            end_err++;
        end
        errs     = total_errors() - err_mark;
        err_mark = total_errors();
        tests_run++;
        if (errs != 0)
            tests_failed++;
        $display("test %0d %s: %s", tests_run, name, (errs == 0) ? "ok" : "FAILED");
    endtask

    initial
    begin
        logic [15:0] r;
        rst      = 1'b1;
        insn     = '0;
        work_en  = 1'b0;
        w_opcode = '0;
        m_add    = '{16'd0, 16'd0, 16'd0};
        m_mul    = '{16'd1, 16'd1, 16'd1};
        m_cmp    = '0;
        for (int a = 0; a < 4096; a++)
        begin
            for (int l = 0; l < LANES; l++)
                acc_mem[a][l*16 +: 16] = rand16();
        end
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        repeat (10) @(negedge clk);
        end_test("quiet after reset");

        run_compute(12'h010, 12'h100, 10'h000, 5'd0, 12'd5, 2'd0, 1'b0);
        end_test("bypass to input ram");

        // reset constants still apply here
        load_op(10'h020, make_op(OP_ADD, 1'b1, 2'd0));
        load_op(10'h021, make_op(OP_ACC, 1'b0, 2'd0));
        load_op(10'h022, make_op(OP_MUL, 1'b1, 2'd1));
        load_op(10'h023, make_op(OP_ACC, 1'b0, 2'd0));
        load_op(10'h024, make_op(OP_MAX, 1'b0, 2'd0));
        run_compute(12'h040, 12'h800, 10'h020, 5'd5, 12'd3, 2'd2, 1'b1);
        end_test("constant register to accumulator");

        run_config(16'd5, 16'hFFFD, 16'd100, 16'd3, 16'hFFFE, 16'd7, 16'hFFCE);
        for (int j = 0; j < 6; j++)
        begin
            r = rand16();
            load_op(10'h080 + 10'(j), make_op(4'(r % 16'd3) + 4'd1, 1'b0, r[9:8]));
        end
        run_compute(12'h060, 12'h200, 10'h080, 5'd6, 12'd4, 2'd1, 1'b1);
        end_test("config then random ops to ofmap");

        run_compute(12'h070, 12'h300, 10'h080, 5'd6, 12'd2, 2'd3, 1'b1);
        end_test("discarded results");

        run_compute(12'h090, 12'h400, 10'h080, 5'd0, 12'd3, 2'd0, 1'b1);
        end_test("engine with no micro-ops");

        $display("%0d tests run, %0d failed, %0d check errors",
                 tests_run, tests_failed, total_errors());
        if (tests_failed == 0 && total_errors() == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/vcu_insn_decoder.sv
`default_nettype none

module vcu_insn_decoder
    import vcu_insn_pkg::*;
    import vcu_op_pkg::*;
(
    input  wire              clk,
    input  wire              rst,
    input  wire vcu_insn_u   insn,
    input  wire              work_en,
    input  wire              load_consts,
    input  wire              done,
    output vcu_insn_u        cur_insn,
    output logic             work,
    output vcu_consts_t      consts
);

    // instruction word held for the whole run
    always_ff @(posedge clk)
    begin
        if (work_en)
            cur_insn <= insn;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            work <= 1'b0;
        else if (work_en)
            work <= 1'b1;
        else if (done)
            work <= 1'b0;
    end

    // scalar operands for the vector ops
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            consts.add_const     <= '0;
            consts.mul_const     <= {3{16'd1}};
            consts.compare_const <= '0;
        end
        else if (load_consts)
        begin
            consts.add_const     <= cur_insn.cfg.add_const;
            consts.mul_const     <= cur_insn.cfg.mul_const;
            consts.compare_const <= cur_insn.cfg.compare_const;
        end
    end

endmodule

`default_nettype wire

//--- verilog/vcu_insn_pkg.sv
`default_nettype none

package vcu_insn_pkg;

    localparam int ADDR_WIDTH        = 12;
    localparam int OPCODE_ADDR_WIDTH = 10;

    // compute view, insn_type 0
    typedef struct packed {
        logic [ADDR_WIDTH-1:0]        data_in_addr;
        logic [ADDR_WIDTH-1:0]        data_out_addr;
        logic [OPCODE_ADDR_WIDTH-1:0] opcode_addr;
        logic [4:0]                   opcode_count;
        logic [ADDR_WIDTH-1:0]        compute_length;
        logic [1:0]                   out_mode;
        logic                         fpu_work;
        logic [69:0]                  reserved;
        logic                         insn_type;
        logic [2:0]                   reserved_lo;
    } vcu_compute_insn_t;

    // configuration view, insn_type 1
    typedef struct packed {
        logic [11:0]      reserved;
        logic [15:0]      compare_const;
        logic [2:0][15:0] mul_const;
        logic [2:0][15:0] add_const;
        logic             insn_type;
        logic [2:0]       reserved_lo;
    } vcu_config_insn_t;

    typedef union packed {
        vcu_compute_insn_t comp;
        vcu_config_insn_t  cfg;
    } vcu_insn_u;

endpackage

`default_nettype wire

//--- verilog/vcu_microcode_engine.sv
`default_nettype none

module vcu_microcode_engine
    import vcu_insn_pkg::*;
    import vcu_op_pkg::*;
#(
    parameter int LANES = 8
)
(
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          start,
    input  wire [LANES*16-1:0]           data_in,
    input  wire [OPCODE_ADDR_WIDTH-1:0]  opcode_addr,
    input  wire [4:0]                    opcode_count,
    input  wire micro_op_t               op,
    input  wire vcu_consts_t             consts,
    output logic                         r_en,
    output logic [OPCODE_ADDR_WIDTH-1:0] r_addr,
    output logic [LANES*16-1:0]          result,
    output logic                         result_valid
);

    logic                         busy;
    logic                         exec;
    logic [4:0]                   op_cnt;
    logic [OPCODE_ADDR_WIDTH-1:0] pc;
    logic [LANES*16-1:0]          iter_reg;
    logic [LANES*16-1:0]          const_reg;
    logic [LANES*16-1:0]          alu_value;

    // op on the ram output belongs to step op_cnt
    assign exec   = busy && (op_cnt < opcode_count);
    assign r_en   = start || busy;
    assign r_addr = start ? opcode_addr : pc;
    assign result = iter_reg;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            busy         <= 1'b0;
            op_cnt       <= '0;
            pc           <= '0;
            result_valid <= 1'b0;
        end
        else
        begin
            result_valid <= busy && !exec;
            if (start)
            begin
                busy   <= 1'b1;
                op_cnt <= '0;
                pc     <= opcode_addr + 1'b1;
            end
            else if (busy)
            begin
                pc <= pc + 1'b1;
                if (exec)
                    op_cnt <= op_cnt + 1'b1;
                else
                    busy <= 1'b0;
            end
        end
    end

    ////////////////////
    // vector registers
    ////////////////////
    always_ff @(posedge clk)
    begin
        if (start)
            const_reg <= '0;
        else if (exec && op.dest)
            const_reg <= alu_value;
    end

    // follows the accumulator read port when idle, so start finds the fresh vector
    always_ff @(posedge clk)
    begin
        if (exec && !op.dest)
            iter_reg <= alu_value;
        else if (!busy && !start && !result_valid)
            iter_reg <= data_in;
    end

    vcu_vector_alu #(
        .LANES (LANES)
    ) i_vector_alu (
        .op         (op),
        .consts     (consts),
        .iter_data  (iter_reg),
        .const_data (const_reg),
        .value      (alu_value)
    );

endmodule

`default_nettype wire

//--- verilog/vcu_op_pkg.sv
`default_nettype none

package vcu_op_pkg;

    import vcu_insn_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        DATA_PREPARE,
        COMPUTE,
        PARA_CONFIG,
        OVER
    } vcu_state_e;

    ////////////////////
    // micro-op encoding
    ////////////////////
    localparam logic [3:0] OP_PASS = 4'd0;
    localparam logic [3:0] OP_ADD  = 4'd1;
    localparam logic [3:0] OP_MUL  = 4'd2;
    localparam logic [3:0] OP_MAX  = 4'd3;
    localparam logic [3:0] OP_ACC  = 4'd4;

    typedef struct packed {
        logic [8:0] reserved;
        logic [3:0] op;
        logic       dest;   // 0 iteration reg, 1 constant reg
        logic [1:0] sel;
    } micro_op_t;

    typedef struct packed {
        logic [2:0][15:0] add_const;
        logic [2:0][15:0] mul_const;
        logic [15:0]      compare_const;
    } vcu_consts_t;

    ////////////////////
    // ram ports
    ////////////////////
    typedef struct packed {
        logic                  en;
        logic [ADDR_WIDTH-1:0] addr;
    } ram_wr_t;

    typedef struct packed {
        logic                         en;
        logic [OPCODE_ADDR_WIDTH-1:0] addr;
        logic [15:0]                  data;
    } opcode_wr_t;

endpackage

`default_nettype wire

//--- verilog/vcu_opcode_ram.sv
`default_nettype none

module vcu_opcode_ram
    import vcu_insn_pkg::*;
    import vcu_op_pkg::*;
(
    input  wire                         clk,
    input  wire opcode_wr_t             wr,
    input  wire                         r_en,
    input  wire [OPCODE_ADDR_WIDTH-1:0] r_addr,
    output micro_op_t                   r_data
);

    micro_op_t mem [1 << OPCODE_ADDR_WIDTH];

    always_ff @(posedge clk)
    begin
        if (wr.en)
            mem[wr.addr] <= wr.data;
    end

    // registered read, data one cycle after r_en
    always_ff @(posedge clk)
    begin
        if (r_en)
            r_data <= mem[r_addr];
    end

endmodule

`default_nettype wire

//--- verilog/vcu_sequencer.sv
`default_nettype none

module vcu_sequencer
    import vcu_insn_pkg::*;
    import vcu_op_pkg::*;
#(
    parameter int LANES = 8
)
(
    input  wire                    clk,
    input  wire                    rst,
    input  wire vcu_insn_u         cur_insn,
    input  wire                    work,
    input  wire                    result_valid,
    output logic                   load_consts,
    output logic                   r_en_acc,
    output logic [ADDR_WIDTH-1:0]  r_addr_acc,
    output logic                   start,
    output logic                   wb_en,
    output logic [ADDR_WIDTH-1:0]  wb_addr,
    output logic                   vcu_done
);

    vcu_state_e            state;
    vcu_state_e            next_state;
    logic                  dp_phase;
    logic                  over_q;
    logic                  over_entry;
    logic                  last_iter;
    logic                  has_write;
    logic [ADDR_WIDTH-1:0] iter_cnt;
    logic [2:0]            done_pipe;

    assign last_iter  = cur_insn.comp.insn_type ||
                        (iter_cnt == cur_insn.comp.compute_length);
    assign has_write  = !cur_insn.comp.insn_type && (cur_insn.comp.out_mode != 2'd3);
    assign over_entry = (state == OVER) && !over_q;

    ////////////////////
    // state machine
    ////////////////////
    always_comb
    begin
        next_state = state;
        case (state)
            IDLE:
            begin
                if (work)
                    next_state = cur_insn.comp.insn_type ? PARA_CONFIG : DATA_PREPARE;
            end
            DATA_PREPARE:
            begin
                // second cycle has the accumulator word on the bus
                if (dp_phase)
                    next_state = cur_insn.comp.fpu_work ? COMPUTE : OVER;
            end
            COMPUTE:
            begin
                if (result_valid)
                    next_state = OVER;
            end
            PARA_CONFIG:
                next_state = OVER;
            OVER:
            begin
                if (vcu_done)
                    next_state = IDLE;
                else if (!last_iter)
                    next_state = DATA_PREPARE;
            end
            default:
                next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state     <= IDLE;
            dp_phase  <= 1'b0;
            over_q    <= 1'b0;
            start     <= 1'b0;
            done_pipe <= '0;
        end
        else
        begin
            state     <= next_state;
            dp_phase  <= (state == DATA_PREPARE) && !dp_phase;
            over_q    <= (state == OVER);
            start     <= (state == DATA_PREPARE) && dp_phase && cur_insn.comp.fpu_work;
            done_pipe <= {done_pipe[1:0], over_entry && last_iter};
        end
    end

    ////////////////////
    // address counters
    ////////////////////
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            iter_cnt   <= '0;
            r_addr_acc <= '0;
            wb_addr    <= '0;
        end
        else if (state == IDLE)
        begin
            iter_cnt   <= '0;
            r_addr_acc <= cur_insn.comp.data_in_addr;
            wb_addr    <= cur_insn.comp.data_out_addr;
        end
        else if (over_entry && !last_iter)
        begin
            iter_cnt   <= iter_cnt + 1'b1;
            r_addr_acc <= r_addr_acc + 1'b1;
            wb_addr    <= wb_addr + 1'b1;
        end
    end

    assign load_consts = (state == PARA_CONFIG);
    assign r_en_acc    = (state == DATA_PREPARE) && !dp_phase;
    assign wb_en       = over_entry && !cur_insn.comp.insn_type;
    // one extra cycle when the last vector still has to land in a RAM
    assign vcu_done    = has_write ? done_pipe[2] : done_pipe[1];

endmodule

`default_nettype wire

//--- verilog/vcu_top.sv
`default_nettype none

module vcu_top
    import vcu_insn_pkg::*;
    import vcu_op_pkg::*;
#(
    parameter int LANES = 8
)
(
    input  wire                   clk,
    input  wire                   rst,
    input  wire vcu_insn_u        insn,
    input  wire                   work_en,
    input  wire opcode_wr_t       w_opcode,
    input  wire [LANES*16-1:0]    r_data_acc,
    output logic                  r_en_acc,
    output logic [ADDR_WIDTH-1:0] r_addr_acc,
    output logic [LANES*16-1:0]   w_data,
    output ram_wr_t               w_inp,
    output ram_wr_t               w_ofmap,
    output ram_wr_t               w_acc,
    output logic                  vcu_done
);

    vcu_insn_u                    cur_insn;
    vcu_consts_t                  consts;
    logic                         work;
    logic                         load_consts;
    logic                         start;
    logic                         result_valid;
    logic                         wb_en;
    logic [ADDR_WIDTH-1:0]        wb_addr;
    logic                         op_r_en;
    logic [OPCODE_ADDR_WIDTH-1:0] op_r_addr;
    micro_op_t                    op;
    logic [LANES*16-1:0]          result;

    vcu_insn_decoder i_insn_decoder (
        .clk         (clk),
        .rst         (rst),
        .insn        (insn),
        .work_en     (work_en),
        .load_consts (load_consts),
        .done        (vcu_done),
        .cur_insn    (cur_insn),
        .work        (work),
        .consts      (consts)
    );

    vcu_sequencer #(
        .LANES (LANES)
    ) i_sequencer (
        .clk          (clk),
        .rst          (rst),
        .cur_insn     (cur_insn),
        .work         (work),
        .result_valid (result_valid),
        .load_consts  (load_consts),
        .r_en_acc     (r_en_acc),
        .r_addr_acc   (r_addr_acc),
        .start        (start),
        .wb_en        (wb_en),
        .wb_addr      (wb_addr),
        .vcu_done     (vcu_done)
    );

    vcu_opcode_ram i_opcode_ram (
        .clk    (clk),
        .wr     (w_opcode),
        .r_en   (op_r_en),
        .r_addr (op_r_addr),
        .r_data (op)
    );

    vcu_microcode_engine #(
        .LANES (LANES)
    ) i_microcode_engine (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .data_in      (r_data_acc),
        .opcode_addr  (cur_insn.comp.opcode_addr),
        .opcode_count (cur_insn.comp.opcode_count),
        .op           (op),
        .consts       (consts),
        .r_en         (op_r_en),
        .r_addr       (op_r_addr),
        .result       (result),
        .result_valid (result_valid)
    );

    vcu_writeback #(
        .LANES (LANES)
    ) i_writeback (
        .clk      (clk),
        .rst      (rst),
        .wb_en    (wb_en),
        .wb_addr  (wb_addr),
        .out_mode (cur_insn.comp.out_mode),
        .result   (result),
        .w_data   (w_data),
        .w_inp    (w_inp),
        .w_ofmap  (w_ofmap),
        .w_acc    (w_acc)
    );

endmodule

`default_nettype wire

//--- verilog/vcu_vector_alu.sv
`default_nettype none

module vcu_vector_alu
    import vcu_op_pkg::*;
#(
    parameter int LANES = 8
)
(
    input  wire micro_op_t      op,
    input  wire vcu_consts_t    consts,
    input  wire [LANES*16-1:0]  iter_data,
    input  wire [LANES*16-1:0]  const_data,
    output logic [LANES*16-1:0] value
);

    logic [15:0] add_opnd;
    logic [15:0] mul_opnd;

    // sel 3 gives a zero operand
    always_comb
    begin
        add_opnd = '0;
        mul_opnd = '0;
        if (op.sel != 2'd3)
        begin
            add_opnd = consts.add_const[op.sel];
            mul_opnd = consts.mul_const[op.sel];
        end
    end

    for (genvar l = 0; l < LANES; l++)
    begin : g_lane
        logic signed [15:0] elem;
        logic signed [15:0] acc_elem;
        logic signed [15:0] lane_res;

        assign elem     = iter_data[l*16 +: 16];
        assign acc_elem = const_data[l*16 +: 16];

        // wraps on overflow, mul keeps the low half
        always_comb
        begin
            case (op.op)
                OP_ADD:  lane_res = elem + add_opnd;
                OP_MUL:  lane_res = elem * mul_opnd;
                OP_MAX:  lane_res = (elem > $signed(consts.compare_const)) ?
                                    elem : consts.compare_const;
                OP_ACC:  lane_res = elem + acc_elem;
                default: lane_res = elem;
            endcase
        end

        assign value[l*16 +: 16] = lane_res;
    end

endmodule

`default_nettype wire

//--- verilog/vcu_writeback.sv
`default_nettype none

module vcu_writeback
    import vcu_insn_pkg::*;
    import vcu_op_pkg::*;
#(
    parameter int LANES = 8
)
(
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   wb_en,
    input  wire [ADDR_WIDTH-1:0]  wb_addr,
    input  wire [1:0]             out_mode,
    input  wire [LANES*16-1:0]    result,
    output logic [LANES*16-1:0]   w_data,
    output ram_wr_t               w_inp,
    output ram_wr_t               w_ofmap,
    output ram_wr_t               w_acc
);

    logic [2:0]            dest_hot;
    logic [2:0]            hot_q;
    logic [ADDR_WIDTH-1:0] addr_q;

    // out_mode 3 selects no destination
    assign dest_hot = {wb_en && (out_mode == 2'd2),
                       wb_en && (out_mode == 2'd1),
                       wb_en && (out_mode == 2'd0)};

    always_ff @(posedge clk)
    begin
        if (rst)
            hot_q <= '0;
        else
            hot_q <= dest_hot;
    end

    always_ff @(posedge clk)
    begin
        if (wb_en)
        begin
            addr_q <= wb_addr;
            w_data <= result;
        end
    end

    assign w_inp   = '{en: hot_q[0], addr: addr_q};
    assign w_ofmap = '{en: hot_q[1], addr: addr_q};
    assign w_acc   = '{en: hot_q[2], addr: addr_q};

endmodule

`default_nettype wire
